/* hw/lsuPkg.sv */
// shared types and cache geometry for the load unit; imported by every RTL module
package lsuPkg;

    // cache geometry
    localparam int NUM_WAYS = 4;
    localparam int SET_BITS = 4;
    localparam int WORD_BITS = 2;
    localparam int BYTE_BITS = 2;
    localparam int TAG_BITS = 32 - SET_BITS - WORD_BITS - BYTE_BITS;
    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int WORDS_PER_LINE = 1 << WORD_BITS;

    typedef logic [31:0] Word;
    typedef logic [3:0] LoadId;
    typedef logic [$clog2(NUM_WAYS)-1:0] WayIdx;

    // address split as the cache sees it
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] setIdx;
        logic [WORD_BITS-1:0] wordIdx;
        logic [BYTE_BITS-1:0] byteOff;
    } AddrFields;

    // same 32 bits, either flat or split into cache fields
    typedef union packed {
        Word word;
        AddrFields fields;
    } CacheAddr;

    typedef struct packed {
        logic valid;
        LoadId id;
        CacheAddr addr;
    } LoadReq;

    typedef struct packed {
        logic valid;
        LoadId id;
        Word data;
    } LoadRes;

    typedef struct packed {
        logic valid;
        LoadId id;
    } LoadNack;

    // lineAddr has word and byte bits cleared
    typedef struct packed {
        logic valid;
        CacheAddr lineAddr;
        WayIdx way;
    } CacheMiss;

    // one refill word; first invalidates the way, last validates it
    typedef struct packed {
        logic valid;
        WayIdx way;
        CacheAddr addr;
        Word data;
        logic first;
        logic last;
    } CacheFill;

    typedef struct packed {
        logic valid;
        logic [TAG_BITS-1:0] tag;
    } TagEntry;

    typedef TagEntry [NUM_WAYS-1:0] TagSet;
    typedef Word [NUM_WAYS-1:0] DataSet;

endpackage

/* hw/loadIssue.sv */
// load issue stage; maps ports onto lanes with a rotating start and drives the array reads
`timescale 1ns/1ns

module loadIssue import lsuPkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic clk,
    input  logic rst,
    input  LoadReq [NUM_PORTS-1:0] loadReq,
    input  logic fillBusy,
    output logic [NUM_PORTS-1:0] stall,
    output LoadReq [NUM_PORTS-1:0] laneLoad,
    output CacheAddr [NUM_PORTS-1:0] readAddr
);

    localparam int LANE_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [LANE_BITS-1:0] startIdx;
    logic [LANE_BITS:0] portSum [NUM_PORTS];
    logic [LANE_BITS-1:0] portSel [NUM_PORTS];

    // start index walks through all ports, one step per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            startIdx <= '0;
        end else if (startIdx == LANE_BITS'(NUM_PORTS - 1)) begin
            startIdx <= '0;
        end else begin
            startIdx <= startIdx + 1'b1;
        end
    end

    // a fill owns the arrays, so nothing issues
    assign stall = {NUM_PORTS{fillBusy}};

    always_comb begin
        for (int lane = 0; lane < NUM_PORTS; lane++) begin
            // lane takes port (start + lane) mod NUM_PORTS
            portSum[lane] = {1'b0, startIdx} + (LANE_BITS + 1)'(lane);
            if (portSum[lane] >= (LANE_BITS + 1)'(NUM_PORTS)) begin
                portSum[lane] = portSum[lane] - (LANE_BITS + 1)'(NUM_PORTS);
            end
            portSel[lane] = portSum[lane][LANE_BITS-1:0];

            laneLoad[lane] = loadReq[portSel[lane]];
            laneLoad[lane].valid = loadReq[portSel[lane]].valid && !fillBusy;
            // idle lanes park the read address at zero
            readAddr[lane] = laneLoad[lane].valid ? loadReq[portSel[lane]].addr : '0;
        end
    end

endmodule

/* hw/cacheArrays.sv */
// tag table and data array of the load cache; one registered read port per lane plus the refill port
`timescale 1ns/1ns

module cacheArrays import lsuPkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic clk,
    input  logic rst,
    input  CacheAddr [NUM_PORTS-1:0] readAddr,
    input  CacheFill fill,
    output TagSet [NUM_PORTS-1:0] tagSet,
    output DataSet [NUM_PORTS-1:0] dataSet
);

    // one TagSet per set index
    TagSet tagMem [NUM_SETS];

    // one word per set, way and offset
    Word dataMem [NUM_SETS][NUM_WAYS][WORDS_PER_LINE];

    // tag table
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    tagMem[s][w].valid <= 1'b0;
                end
            end
        end else if (fill.valid) begin
            if (fill.last) begin
                // line complete, publish the tag
                tagMem[fill.addr.fields.setIdx][fill.way].valid <= 1'b1;
                tagMem[fill.addr.fields.setIdx][fill.way].tag <= fill.addr.fields.tag;
            end else if (fill.first) begin
                // old line in this way is gone from here on
                tagMem[fill.addr.fields.setIdx][fill.way].valid <= 1'b0;
            end
        end
    end

    // refill writes one data word per cycle, any order
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            dataMem[fill.addr.fields.setIdx][fill.way][fill.addr.fields.wordIdx] <= fill.data;
        end
    end

    // per-lane reads, all ways of the set at once
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < NUM_PORTS; lane++) begin
            tagSet[lane] <= tagMem[readAddr[lane].fields.setIdx];
            for (int w = 0; w < NUM_WAYS; w++) begin
                dataSet[lane][w] <=
                    dataMem[readAddr[lane].fields.setIdx][w][readAddr[lane].fields.wordIdx];
            end
        end
    end

endmodule

/* hw/loadLane.sv */
// one load lane; two-stage pipeline doing tag compare and answering with result, nack or miss
`timescale 1ns/1ns

module loadLane import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  LoadReq laneLoad,
    input  TagSet tagSet,
    input  DataSet dataSet,
    input  logic resultReady,
    output LoadRes result,
    output LoadNack nack,
    output CacheMiss missCand
);

    // what stage 2 keeps of a load
    typedef struct packed {
        logic valid;
        LoadId id;
        CacheAddr addr;
        logic hit;
        Word word;
    } LaneStage;

    LoadReq s1Load;
    LaneStage s2Next;
    LaneStage s2;

    logic [NUM_WAYS-1:0] wayHit;
    logic tagHit;
    Word hitWord;

    // stage 1 lines up with the array read data
    always_ff @(posedge clk) begin
        s1Load <= laneLoad;
        if (rst) begin
            s1Load.valid <= 1'b0;
        end
    end

    // compare against every way of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            wayHit[w] = tagSet[w].valid && (tagSet[w].tag == s1Load.addr.fields.tag);
        end
        tagHit = |wayHit;
    end

    // a line sits in at most one way, so the first match is the match
    always_comb begin
        hitWord = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (wayHit[w]) begin
                hitWord = dataSet[w];
            end
        end
    end

    always_comb begin
        s2Next.valid = s1Load.valid;
        s2Next.id = s1Load.id;
        s2Next.addr = s1Load.addr;
        s2Next.hit = tagHit;
        s2Next.word = hitWord;
    end

    always_ff @(posedge clk) begin
        s2 <= s2Next;
        if (rst) begin
            s2.valid <= 1'b0;
        end
    end

    // hit and consumer ready gives data
    always_comb begin
        result.valid = s2.valid && s2.hit && resultReady;
        result.id = s2.id;
        result.data = s2.word;
    end

    // anything else goes back to the port for reissue
    always_comb begin
        nack.valid = s2.valid && !(s2.hit && resultReady);
        nack.id = s2.id;
    end

    // only a real tag miss asks for a refill; way comes from the arbiter
    always_comb begin
        missCand = '0;
        missCand.valid = s2.valid && !s2.hit;
        missCand.lineAddr = s2.addr;
        missCand.lineAddr.fields.wordIdx = '0;
        missCand.lineAddr.fields.byteOff = '0;
    end

endmodule

/* hw/missArbiter.sv */
// miss arbiter; forwards the lowest lane's miss and assigns a round-robin victim way
`timescale 1ns/1ns

module missArbiter import lsuPkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic clk,
    input  logic rst,
    input  CacheMiss [NUM_PORTS-1:0] missCand,
    input  logic missReady,
    output CacheMiss miss
);

    WayIdx victim;
    logic found;

    // lowest lane wins, the rest are dropped since they are nacked anyway
    always_comb begin
        miss = '0;
        found = 1'b0;
        for (int lane = 0; lane < NUM_PORTS; lane++) begin
            if (missCand[lane].valid && !found) begin
                miss = missCand[lane];
                found = 1'b1;
            end
        end
        miss.way = victim;
    end

    // victim moves on only when the requester takes the miss
    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= '0;
        end else if (miss.valid && missReady) begin
            if (victim == WayIdx'(NUM_WAYS - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

endmodule

/* hw/lsuTop.sv */
// top of the load unit; connects issue, cache arrays, the lane array and the miss arbiter
`timescale 1ns/1ns

module lsuTop import lsuPkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic clk,
    input  logic rst,
    input  LoadReq [NUM_PORTS-1:0] loadReq,
    output logic [NUM_PORTS-1:0] stall,
    output LoadRes [NUM_PORTS-1:0] result,
    output LoadNack [NUM_PORTS-1:0] nack,
    input  logic [NUM_PORTS-1:0] resultReady,
    output CacheMiss miss,
    input  logic missReady,
    input  CacheFill fill
);

    LoadReq [NUM_PORTS-1:0] laneLoad;
    CacheAddr [NUM_PORTS-1:0] readAddr;
    TagSet [NUM_PORTS-1:0] tagSet;
    DataSet [NUM_PORTS-1:0] dataSet;
    CacheMiss [NUM_PORTS-1:0] missCand;

    // a valid fill word stalls every port
    loadIssue #(.NUM_PORTS(NUM_PORTS)) uLoadIssue (
        .clk(clk),
        .rst(rst),
        .loadReq(loadReq),
        .fillBusy(fill.valid),
        .stall(stall),
        .laneLoad(laneLoad),
        .readAddr(readAddr)
    );

    cacheArrays #(.NUM_PORTS(NUM_PORTS)) uCacheArrays (
        .clk(clk),
        .rst(rst),
        .readAddr(readAddr),
        .fill(fill),
        .tagSet(tagSet),
        .dataSet(dataSet)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : gLane
        loadLane uLoadLane (
            .clk(clk),
            .rst(rst),
            .laneLoad(laneLoad[i]),
            .tagSet(tagSet[i]),
            .dataSet(dataSet[i]),
            .resultReady(resultReady[i]),
            .result(result[i]),
            .nack(nack[i]),
            .missCand(missCand[i])
        );
    end

    missArbiter #(.NUM_PORTS(NUM_PORTS)) uMissArbiter (
        .clk(clk),
        .rst(rst),
        .missCand(missCand),
        .missReady(missReady),
        .miss(miss)
    );

endmodule

/* tests/lsuTop_assert.sv */
// concurrent checks on lane outputs, refill stalls and miss alignment; bound into lsuTop
`timescale 1ns/1ns

module lsuTopAssert import lsuPkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input logic clk,
    input logic rst,
    input LoadReq [NUM_PORTS-1:0] laneLoad,
    input LoadRes [NUM_PORTS-1:0] result,
    input LoadNack [NUM_PORTS-1:0] nack,
    input CacheMiss miss,
    input CacheFill fill
);

    logic anyIssue;

    // some lane took a load this cycle
    always_comb begin
        anyIssue = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            anyIssue = anyIssue | laneLoad[i].valid;
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : gLaneChk
        // never both, and exactly one answer two cycles after the lane took a load
        resultOrNack: assert property (@(posedge clk) disable iff (rst)
            !(result[i].valid && nack[i].valid) &&
            ((result[i].valid || nack[i].valid) ==
                ($past(laneLoad[i].valid && !rst, 2) && !$past(rst))))
            else $error("lane %0d did not give exactly one answer per load", i);

        noIssueInFill: assert property (@(posedge clk) disable iff (rst)
            fill.valid |-> !laneLoad[i].valid)
            else $error("lane %0d took a load during a fill", i);
    end

    lineAligned: assert property (@(posedge clk) disable iff (rst)
        miss.valid |-> (miss.lineAddr.fields.wordIdx == '0 &&
            miss.lineAddr.fields.byteOff == '0 && $past(anyIssue, 2)))
        else $error("miss is not line aligned or has no load behind it");

endmodule

bind lsuTop lsuTopAssert #(.NUM_PORTS(NUM_PORTS)) uLsuTopAssert (
    .clk(clk),
    .rst(rst),
    .laneLoad(laneLoad),
    .result(result),
    .nack(nack),
    .miss(miss),
    .fill(fill)
);

/* tests/lsuTb.sv */
// testbench for lsuTop; replays tests/loadPatterns.txt and acts as requester and refill memory
`timescale 1ns/1ns

module lsuTb import lsuPkg::*;;

    localparam int NUM_PORTS = 2;
    localparam int MAX_PATTERNS = 64;
    localparam Word MEM_KEY = 32'h5a5a0000;

    logic clk = 1'b0;
    logic rst;
    LoadReq [NUM_PORTS-1:0] loadReq;
    logic [NUM_PORTS-1:0] stall;
    LoadRes [NUM_PORTS-1:0] result;
    LoadNack [NUM_PORTS-1:0] nack;
    logic [NUM_PORTS-1:0] resultReady;
    CacheMiss miss;
    logic missReady;
    CacheFill fill;

    // kind, port, id, outcome, byte address, expected data
    logic [79:0] patMem [MAX_PATTERNS];
    int patCount;
    logic [31:0] lfsr;
    WayIdx victimModel;
    logic passed = 1'b0;
    logic failReported = 1'b0;

    lsuTop #(.NUM_PORTS(NUM_PORTS)) u_lsuTop (
        .clk(clk),
        .rst(rst),
        .loadReq(loadReq),
        .stall(stall),
        .result(result),
        .nack(nack),
        .resultReady(resultReady),
        .miss(miss),
        .missReady(missReady),
        .fill(fill)
    );

    always #10 clk = ~clk;

    task automatic reportFail();
        if (!failReported) begin
            failReported = 1'b1;
            $display("TEST FAIL");
        end
    endtask

    task automatic abortRun();
        reportFail();
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic stopOnError(input string why);
        $display("Error at %0t ns: %s", $time, why);
        abortRun();
    endtask

    task automatic checkRes(input LoadRes got, input LoadRes exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkNack(input LoadNack got, input LoadNack exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkMiss(input CacheMiss got, input CacheMiss exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkStall(input logic [NUM_PORTS-1:0] got,
        input logic [NUM_PORTS-1:0] exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic randBits(input int n, output int v);
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsrStep(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // backing memory: word address XOR a fixed key
    function automatic Word memWord(input CacheAddr a);
        return {2'b00, a.word[31:2]} ^ MEM_KEY;
    endfunction

    // takes the miss on the next edge, waits a random delay, then writes the line
    task automatic refillLine(input CacheAddr lineAddr, input WayIdx way);
        int delay;
        int start;
        CacheAddr wa;
        @(posedge clk);
        @(negedge clk);
        missReady = 1'b0;
        randBits(3, delay);
        repeat (delay) @(negedge clk);
        randBits(2, start);
        for (int j = 0; j < WORDS_PER_LINE; j++) begin
            wa.word = lineAddr.word | 32'(((start + j) % WORDS_PER_LINE) * 4);
            fill.valid = 1'b1;
            fill.way = way;
            fill.addr = wa;
            fill.data = memWord(wa);
            fill.first = (j == 0);
            fill.last = (j == WORDS_PER_LINE - 1);
            // every port keeps offering a load that the fill must hold off
            for (int p = 0; p < NUM_PORTS; p++) begin
                loadReq[p] = '{valid: 1'b1, id: LoadId'(p), addr: wa};
            end
            @(posedge clk);
            checkStall(stall, '1, "stall");
            @(negedge clk);
        end
        fill = '0;
        loadReq = '0;
        missReady = 1'b1;
    endtask

    // issues one or two loads in the same cycle until each has returned its data
    task automatic runGroup(input int first, input int n);
        int port [2];
        LoadId id [2];
        CacheAddr addr [2];
        Word data [2];
        logic hitExp [2];
        logic forceLow [2];
        logic done [2];
        int lane [2];
        int attempts;
        int waited;
        int r;
        int missLoad;
        int answers;
        logic rdy;
        CacheMiss expMiss;
        CacheAddr line;
        for (int k = 0; k < n; k++) begin
            port[k] = int'(patMem[first + k][75:72]);
            id[k] = patMem[first + k][71:68];
            hitExp[k] = (patMem[first + k][67:64] != 4'd1);
            forceLow[k] = (patMem[first + k][67:64] == 4'd2);
            addr[k].word = patMem[first + k][63:32];
            data[k] = patMem[first + k][31:0];
            done[k] = 1'b0;
        end
        if (n == 1) begin
            done[1] = 1'b1;
        end
        attempts = 0;
        while (!(done[0] && done[1])) begin
            attempts++;
            if (attempts > 8) begin
                stopOnError("a load still has no data after 8 attempts");
            end
            @(negedge clk);
            // roughly one cycle in four has the consumer busy
            randBits(2, r);
            rdy = (r != 3);
            for (int k = 0; k < n; k++) begin
                if (forceLow[k] && attempts == 1) begin
                    rdy = 1'b0;
                end
                if (!done[k]) begin
                    loadReq[port[k]] = '{valid: 1'b1, id: id[k], addr: addr[k]};
                end
            end
            resultReady = {NUM_PORTS{rdy}};
            do begin
                @(posedge clk);
            end while (stall[port[0]]);
            @(negedge clk);
            loadReq = '0;
            waited = 0;
            answers = 0;
            while (answers == 0) begin
                @(posedge clk);
                waited++;
                @(negedge clk);
                #2;
                for (int l = 0; l < NUM_PORTS; l++) begin
                    answers += int'(result[l].valid || nack[l].valid);
                end
                if (waited > 6) begin
                    stopOnError("no result or nack for an accepted load");
                end
            end
            // answer shows in the second cycle after the accepting one
            if (waited != 1) begin
                stopOnError($sformatf("answer came %0d cycles after acceptance", waited));
            end
            missLoad = -1;
            for (int k = 0; k < n; k++) begin
                lane[k] = -1;
                if (!done[k]) begin
                    for (int l = 0; l < NUM_PORTS; l++) begin
                        if ((result[l].valid && result[l].id == id[k]) ||
                            (nack[l].valid && nack[l].id == id[k])) begin
                            lane[k] = l;
                        end
                    end
                    if (lane[k] < 0) begin
                        stopOnError($sformatf("load id %0d got neither result nor nack", id[k]));
                    end
                    if (!hitExp[k] && (missLoad < 0 || lane[k] < lane[missLoad])) begin
                        missLoad = k;
                    end
                end
            end
            if (answers != (done[0] ? 0 : 1) + (done[1] ? 0 : 1)) begin
                stopOnError("a lane answered without a load in flight");
            end
            for (int k = 0; k < n; k++) begin
                if (!done[k]) begin
                    if (hitExp[k] && rdy) begin
                        checkRes(result[lane[k]], '{valid: 1'b1, id: id[k], data: data[k]},
                            $sformatf("result[%0d]", lane[k]));
                        if (nack[lane[k]].valid) begin
                            stopOnError("a lane gave a nack together with its result");
                        end
                        done[k] = 1'b1;
                    end else begin
                        checkNack(nack[lane[k]], '{valid: 1'b1, id: id[k]},
                            $sformatf("nack[%0d]", lane[k]));
                        if (result[lane[k]].valid) begin
                            stopOnError("a lane gave a result together with its nack");
                        end
                    end
                end
            end
            expMiss = '0;
            expMiss.way = victimModel;
            if (missLoad >= 0) begin
                expMiss.valid = 1'b1;
                expMiss.lineAddr.word = addr[missLoad].word & 32'hffff_fff0;
            end
            checkMiss(miss, expMiss, "miss");
            if (missLoad >= 0) begin
                line = expMiss.lineAddr;
                victimModel = WayIdx'(victimModel + 1'b1);
                refillLine(line, expMiss.way);
                for (int k = 0; k < n; k++) begin
                    if ((addr[k].word & 32'hffff_fff0) == line.word) begin
                        hitExp[k] = 1'b1;
                    end
                end
            end
        end
    endtask

    initial begin
        int i;
        int n;
        lfsr = 32'h25cf9989;
        rst = 1'b1;
        loadReq = '0;
        resultReady = '1;
        missReady = 1'b1;
        fill = '0;
        victimModel = '0;
        for (int p = 0; p < MAX_PATTERNS; p++) begin
            patMem[p] = '0;
        end
        $readmemh("tests/loadPatterns.txt", patMem);
        patCount = 0;
        while (patCount < MAX_PATTERNS && patMem[patCount][79:76] != 4'd0) begin
            patCount++;
        end
        if (patCount == 0) begin
            stopOnError("pattern file is empty or missing");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        i = 0;
        while (i < patCount) begin
            n = (patMem[i][79:76] == 4'd2) ? 2 : 1;
            runGroup(i, n);
            i += n;
        end
        repeat (4) @(negedge clk);
        passed = 1'b1;
        $display("TEST PASS");
        $finish;
    end

    // 200 cycles per pattern line
    initial begin
        #1;
        repeat (patCount * 200) @(posedge clk);
        stopOnError("watchdog expired before all patterns finished");
    end

    // covers runs stopped by an assertion
    final begin
        if (!passed) begin
            reportFail();
        end
    end

endmodule

/* tests/loadPatterns.txt */
// kind(1 single or last of pair, 2 issue with next) port id outcome byteAddr expectedData
// outcome 0 hit, 1 cold miss, 2 hit with resultReady held low on the first try
1_0_1_1_00000010_5a5a0004
1_1_2_1_00000024_5a5a0009
1_0_3_1_00000038_5a5a000e
1_1_4_1_0000004c_5a5a0013
1_1_5_0_00000014_5a5a0005
2_0_6_0_00000028_5a5a000a
1_1_7_0_0000003c_5a5a000f
2_0_8_1_00000060_5a5a0018
1_1_9_1_00000074_5a5a001d
1_1_a_2_00000018_5a5a0006
1_0_b_1_00000080_5a5a0020
1_1_c_1_00000094_5a5a0025
1_0_d_1_00001050_5a5a0414
1_1_e_1_00002050_5a5a0814
1_0_f_1_00003050_5a5a0c14
1_1_0_1_00004050_5a5a1014
1_0_1_1_00005050_5a5a1414
1_1_2_1_00001054_5a5a0415
1_0_3_0_00005058_5a5a1416

/* sources.f */
hw/lsuPkg.sv
hw/loadIssue.sv
hw/cacheArrays.sv
hw/loadLane.sv
hw/missArbiter.sv
hw/lsuTop.sv
tests/lsuTop_assert.sv
tests/lsuTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module lsuTb -f sources.f -o lsuSim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/lsuSim > sim.log 2>&1 || true
grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation gave no verdict, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
